// File: run_sim.sh
#!/bin/sh
# Build the CSR unit testbench with Verilator and run it.
# Exit status is zero only when the pass message shows up in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module csr_unit_tb \
    -f sources.f -o csr_unit_sim &&
./obj_dir/csr_unit_sim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: sources.f
verilog/csr_pkg.sv
verilog/csr_bus_if.sv
verilog/csr_access_decode.sv
verilog/csr_trap_regs.sv
verilog/csr_intr_pending.sv
verilog/csr_counters.sv
verilog/csr_unit_top.sv
test/csr_unit_tb.sv

// File: test/csr_unit_tb.sv
//--------------------------------------------------------------------------
// Directed testbench for the machine-level CSR unit. Runs reset and
// read/write, trap entry and return, interrupt pending, counter and access
// exception tests, and prints one line per test plus the totals.
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_unit_tb;

    localparam int             HART_ID_TB      = 5;
    localparam int             RESET_CYCLES    = 5;
    localparam int             MIP_LATENCY     = 2;   // Drive edge to visible mip
    localparam int             MIP_TIMEOUT     = 16;
    localparam int             WATCHDOG_CYCLES = 5000;
    localparam logic [31:0]    LFSR_SEED       = 32'd84764;
    localparam logic [31:0]    LFSR_TAPS       = 32'hD000_0001;

    localparam csr_pkg::xlen_t MIE_MASK        = 32'h0000_0008;
    localparam csr_pkg::xlen_t MPIE_MASK       = 32'h0000_0080;
    localparam csr_pkg::xlen_t MPP_MASK        = 32'h0000_1800;
    localparam csr_pkg::xlen_t MSTATUS_RST_EXP = MPP_MASK | MPIE_MASK;
    localparam csr_pkg::xlen_t MISA_EXP        = (32'd1 << 30) | (32'd1 << 12) | (32'd1 << 8);
    localparam csr_pkg::xlen_t MIE_BITS        = 32'h0000_0888;  // MEI, MTI, MSI

    logic               clk, rst_n;
    logic               rd_vld, wb_act, wr_vld;
    csr_pkg::csr_idx_t  rd_idx, wr_idx;
    csr_pkg::xlen_t     rd_data, wr_data;
    csr_pkg::priv_e     pri_level;
    logic               trap_trig, trap_exit, trap_is_intr;
    logic [3:0]         trap_code;
    csr_pkg::xlen_t     trap_epc, trap_info;
    logic               intr_ext, intr_tmr, intr_sft, instret_inc;
    csr_pkg::xlen_t     out_mepc, out_mtvec;
    logic               out_mstatus_mie, out_mie_meie, out_mie_mtie, out_mie_msie;
    logic               csr_excp;

    int                 errors = 0;
    int                 checks = 0;
    int                 tests  = 0;
    logic [31:0]        lfsr_state;

    csr_unit_top #(.HART_ID(HART_ID_TB)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------------------------------
    // Random bits and compare tasks
    function automatic logic next_rand_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ LFSR_TAPS;
        return out;
    endfunction

    function automatic csr_pkg::xlen_t rand_bits(input int n);
        csr_pkg::xlen_t w;
        int             i;
        w = '0;
        for (i = 0; i < n; i++) w = {w[csr_pkg::XLEN-2:0], next_rand_bit()};
        return w;
    endfunction

    task automatic check_word(input string name, input csr_pkg::xlen_t got,
                              input csr_pkg::xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_cnt(input string name, input csr_pkg::cnt_t got,
                             input csr_pkg::cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) $display("test %0d %s: ok", tests, name);
        else $display("test %0d %s: %0d errors", tests, name, errors - start_errors);
    endtask

    // --------------------------------------------------------------------------
    // Bus helpers, all inputs change on the falling edge
    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic read_csr(input csr_pkg::csr_idx_t idx, input logic wb,
                            output csr_pkg::xlen_t data, output logic excp);
        @(negedge clk);
        rd_vld = 1'b1;
        rd_idx = idx;
        wb_act = wb;
        #2;                      // Combinational read settles
        data = rd_data;
        excp = csr_excp;
    endtask

    task automatic write_csr(input csr_pkg::csr_idx_t idx, input csr_pkg::xlen_t data);
        @(negedge clk);
        wr_vld  = 1'b1;
        wr_idx  = idx;
        wr_data = data;
        @(negedge clk);
        wr_vld  = 1'b0;
    endtask

    task automatic read_cnt(input csr_pkg::csr_idx_t lo_idx, input csr_pkg::csr_idx_t hi_idx,
                            output csr_pkg::cnt_t val);
        csr_pkg::xlen_t lo, hi;
        logic           excp;
        read_csr(lo_idx, 1'b0, lo, excp);
        read_csr(hi_idx, 1'b0, hi, excp);
        val = {hi, lo};
    endtask

    task automatic set_priv(input csr_pkg::priv_e p);
        @(negedge clk);
        pri_level = p;
    endtask

    task automatic set_line(input int line, input logic v);
        @(negedge clk);
        case (line)
            0:       intr_ext = v;
            1:       intr_tmr = v;
            default: intr_sft = v;
        endcase
    endtask

    function automatic csr_pkg::xlen_t line_mask(input int line);
        case (line)
            0:       return 32'h0000_0800;
            1:       return 32'h0000_0080;
            default: return 32'h0000_0008;
        endcase
    endfunction

    // Polls mip until it shows exp, then checks how long that took
    task automatic wait_mip(input csr_pkg::xlen_t exp);
        csr_pkg::xlen_t val;
        logic           excp;
        int             n;
        n   = 0;
        val = ~exp;
        while (val !== exp && n < MIP_TIMEOUT) begin
            read_csr(csr_pkg::MIP, 1'b0, val, excp);
            n++;
        end
        checks++;
        if (val !== exp) begin
            errors++;
            $display("mip never reached %h within %0d cycles, last value %h", exp, n, val);
        end else if (n != MIP_LATENCY) begin
            errors++;
            $display("mip reached %h after %0d cycles instead of %0d", exp, n, MIP_LATENCY);
        end
    endtask

    // --------------------------------------------------------------------------
    // Tests
    task automatic reset_and_rw();
        csr_pkg::xlen_t val, w;
        logic           excp;
        int             start;
        start = errors;
        check_bit("csr_excp", csr_excp, 1'b0);      // rd_vld still low
        check_bit("out_mstatus_mie", out_mstatus_mie, 1'b0);
        check_bit("out_mie_meie", out_mie_meie, 1'b0);
        check_bit("out_mie_mtie", out_mie_mtie, 1'b0);
        check_bit("out_mie_msie", out_mie_msie, 1'b0);
        read_csr(csr_pkg::MSTATUS, 1'b0, val, excp);
        check_word("mstatus", val, MSTATUS_RST_EXP);
        read_csr(csr_pkg::MISA, 1'b0, val, excp);
        check_word("misa", val, MISA_EXP);
        read_csr(csr_pkg::MHARTID, 1'b0, val, excp);
        check_word("mhartid", val, csr_pkg::xlen_t'(HART_ID_TB));
        check_bit("csr_excp", excp, 1'b0);
        w = rand_bits(32);
        write_csr(csr_pkg::MSCRATCH, w);
        read_csr(csr_pkg::MSCRATCH, 1'b0, val, excp);
        check_word("mscratch", val, w);
        w = rand_bits(32);
        write_csr(csr_pkg::MTVEC, w);
        check_word("out_mtvec", out_mtvec, w & ~32'h2);
        read_csr(csr_pkg::MTVEC, 1'b0, val, excp);
        check_word("mtvec", val, w & ~32'h2);
        w = rand_bits(32);
        write_csr(csr_pkg::MSTATUS, w);
        read_csr(csr_pkg::MSTATUS, 1'b0, val, excp);
        check_word("mstatus", val, MPP_MASK | (w & (MIE_MASK | MPIE_MASK)));
        report_test("reset and read/write", start);
    endtask

    task automatic trap_entry_return();
        csr_pkg::xlen_t val, epc, info, tmp;
        logic           excp, is_intr;
        logic [3:0]     code;
        int             start;
        start = errors;
        write_csr(csr_pkg::MSTATUS, MIE_MASK);
        check_bit("out_mstatus_mie", out_mstatus_mie, 1'b1);
        epc     = rand_bits(32);
        info    = rand_bits(32);
        tmp     = rand_bits(4);
        code    = tmp[3:0];
        is_intr = next_rand_bit();
        @(negedge clk);
        trap_trig    = 1'b1;
        trap_is_intr = is_intr;
        trap_code    = code;
        trap_epc     = epc;
        trap_info    = info;
        @(negedge clk);
        trap_trig    = 1'b0;
        check_word("out_mepc", out_mepc, epc);
        check_bit("out_mstatus_mie", out_mstatus_mie, 1'b0);
        read_csr(csr_pkg::MSTATUS, 1'b0, val, excp);
        check_word("mstatus", val, MPP_MASK | MPIE_MASK);
        read_csr(csr_pkg::MCAUSE, 1'b0, val, excp);
        check_word("mcause", val, {is_intr, 27'd0, code});
        read_csr(csr_pkg::MTVAL, 1'b0, val, excp);
        check_word("mtval", val, info);
        @(negedge clk);
        trap_exit = 1'b1;
        @(negedge clk);
        trap_exit = 1'b0;
        check_bit("out_mstatus_mie", out_mstatus_mie, 1'b1);
        read_csr(csr_pkg::MSTATUS, 1'b0, val, excp);
        check_word("mstatus", val, MPP_MASK | MPIE_MASK | MIE_MASK);
        report_test("trap entry and return", start);
    endtask

    task automatic intr_pending_edges();
        csr_pkg::xlen_t val, mask, w;
        logic           excp;
        int             line, k, start;
        start = errors;
        mask  = '0;
        for (line = 0; line < 3; line++) begin
            set_line(line, 1'b1);
            mask = mask | line_mask(line);
            wait_mip(mask);
        end
        for (line = 0; line < 3; line++) begin
            set_line(line, 1'b0);
            mask = mask & ~line_mask(line);
            wait_mip(mask);
        end
        // Edges seen at user level leave mip alone
        set_line(0, 1'b1);
        wait_mip(line_mask(0));
        @(negedge clk);
        pri_level = csr_pkg::PRIV_U;
        intr_ext  = 1'b0;
        intr_tmr  = 1'b1;
        idle_cycles(4);
        set_priv(csr_pkg::PRIV_M);
        read_csr(csr_pkg::MIP, 1'b0, val, excp);
        check_word("mip", val, line_mask(0));
        @(negedge clk);
        intr_tmr = 1'b0;
        intr_ext = 1'b1;
        idle_cycles(4);
        set_line(0, 1'b0);
        wait_mip('0);
        for (k = 0; k < 2; k++) begin
            w = rand_bits(32);
            write_csr(csr_pkg::MIE, w);
            check_bit("out_mie_meie", out_mie_meie, w[11]);
            check_bit("out_mie_mtie", out_mie_mtie, w[7]);
            check_bit("out_mie_msie", out_mie_msie, w[3]);
            read_csr(csr_pkg::MIE, 1'b0, val, excp);
            check_word("mie", val, w & MIE_BITS);
        end
        report_test("interrupt pending", start);
    endtask

    task automatic counter_behaviour();
        csr_pkg::xlen_t val, a, b, w;
        csr_pkg::cnt_t  c0, c1;
        logic           excp;
        int             n, i, count, start;
        start = errors;
        read_cnt(csr_pkg::MCYCLE, csr_pkg::MCYCLEH, c0);
        idle_cycles(6);
        read_cnt(csr_pkg::MCYCLE, csr_pkg::MCYCLEH, c1);
        check_cnt("mcycle", c1, c0);                // Inhibited after reset
        read_csr(csr_pkg::MCOUNTINHIBIT, 1'b0, val, excp);
        check_word("mcountinhibit", val, 32'hFFFF_FFFD);
        write_csr(csr_pkg::MCOUNTINHIBIT, 32'hFFFF_FFFF);
        read_csr(csr_pkg::MCOUNTINHIBIT, 1'b0, val, excp);
        check_word("mcountinhibit", val, 32'hFFFF_FFFD);
        write_csr(csr_pkg::MCOUNTINHIBIT, '0);
        n = 5 + int'(rand_bits(4));
        read_csr(csr_pkg::MCYCLE, 1'b0, a, excp);
        idle_cycles(n - 1);
        read_csr(csr_pkg::MCYCLE, 1'b0, b, excp);
        check_cnt("mcycle delta", {32'd0, b - a}, csr_pkg::cnt_t'(n));
        write_csr(csr_pkg::MINSTRET, '0);
        count = 0;
        for (i = 0; i < 16; i++) begin
            @(negedge clk);
            instret_inc = next_rand_bit();
            if (instret_inc) count++;
        end
        @(negedge clk);
        instret_inc = 1'b0;
        read_cnt(csr_pkg::INSTRET, csr_pkg::INSTRETH, c0);
        check_cnt("minstret", c0, csr_pkg::cnt_t'(count));
        w = rand_bits(32);
        write_csr(csr_pkg::MCYCLEH, w);
        read_csr(csr_pkg::CYCLEH, 1'b0, val, excp);
        check_word("cycleh", val, w);
        report_test("counters", start);
    endtask

    task automatic access_exceptions();
        csr_pkg::xlen_t val, w1, w2;
        logic           excp;
        int             start;
        start = errors;
        read_csr(12'h302, 1'b0, val, excp);         // medeleg, not kept
        check_bit("csr_excp", excp, 1'b1);
        check_word("rd_data", val, '0);
        w1 = rand_bits(32);
        w2 = ~w1;
        write_csr(csr_pkg::MSCRATCH, w1);
        set_priv(csr_pkg::PRIV_U);
        read_csr(csr_pkg::MSCRATCH, 1'b0, val, excp);
        check_bit("csr_excp", excp, 1'b1);
        check_word("rd_data", val, '0);
        read_csr(csr_pkg::CYCLE, 1'b0, val, excp);
        check_bit("csr_excp", excp, 1'b0);
        read_csr(csr_pkg::INSTRET, 1'b1, val, excp);
        check_bit("csr_excp", excp, 1'b1);
        write_csr(csr_pkg::MSCRATCH, w2);
        set_priv(csr_pkg::PRIV_M);
        read_csr(csr_pkg::MSCRATCH, 1'b0, val, excp);
        check_word("mscratch", val, w1);
        @(negedge clk);
        rd_vld = 1'b0;
        wb_act = 1'b0;
        #2;
        check_bit("csr_excp", csr_excp, 1'b0);
        report_test("access exceptions", start);
    endtask

    // --------------------------------------------------------------------------
    // Main sequence and watchdog
    initial begin
        rd_vld       = 1'b0;
        wb_act       = 1'b0;
        rd_idx       = '0;
        wr_vld       = 1'b0;
        wr_idx       = '0;
        wr_data      = '0;
        pri_level    = csr_pkg::PRIV_M;
        trap_trig    = 1'b0;
        trap_exit    = 1'b0;
        trap_is_intr = 1'b0;
        trap_code    = '0;
        trap_epc     = '0;
        trap_info    = '0;
        intr_ext     = 1'b0;
        intr_tmr     = 1'b0;
        intr_sft     = 1'b0;
        instret_inc  = 1'b0;
        lfsr_state   = LFSR_SEED;
        rst_n        = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        reset_and_rw();
        trap_entry_return();
        intr_pending_edges();
        counter_behaviour();
        access_exceptions();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: verilog/csr_access_decode.sv
//--------------------------------------------------------------------------
// CSR index decode and access check. Raises csr_excp on a read of an
// unknown index, on too low a privilege or on a write-back to a read-only
// CSR, qualifies writes, and muxes the block read values into rd_data.
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_access_decode #(
    parameter int HART_ID = 0
) (
    input  logic                  rd_vld,
    input  logic                  wb_act,
    input  csr_pkg::csr_idx_t     rd_idx,
    input  logic                  wr_vld,
    input  csr_pkg::csr_idx_t     wr_idx,
    input  csr_pkg::xlen_t        wr_data,
    input  csr_pkg::priv_e        pri_level,
    input  csr_pkg::xlen_t        trap_rd_data,
    input  csr_pkg::xlen_t        intr_rd_data,
    input  csr_pkg::xlen_t        cnt_rd_data,
    output csr_pkg::xlen_t        rd_data,
    output logic                  csr_excp,
    csr_access_if.decoder         acc
);

    csr_pkg::xlen_t rd_mux;

    function automatic logic idx_exists(csr_pkg::csr_idx_t idx);
        logic hit;
        case (idx)
            csr_pkg::MSTATUS, csr_pkg::MISA, csr_pkg::MIE, csr_pkg::MTVEC,
            csr_pkg::MCOUNTINHIBIT, csr_pkg::MSCRATCH, csr_pkg::MEPC,
            csr_pkg::MCAUSE, csr_pkg::MTVAL, csr_pkg::MIP,
            csr_pkg::MCYCLE, csr_pkg::MINSTRET, csr_pkg::MCYCLEH, csr_pkg::MINSTRETH,
            csr_pkg::CYCLE, csr_pkg::INSTRET, csr_pkg::CYCLEH, csr_pkg::INSTRETH,
            csr_pkg::MHARTID: hit = 1'b1;
            default:          hit = 1'b0;
        endcase
        return hit;
    endfunction

    // Read side check, combinational
    assign csr_excp = rd_vld && (!idx_exists(rd_idx) || (rd_idx[9:8] > pri_level) ||
                                 (wb_act && (rd_idx[11:10] == csr_pkg::RO_FIELD_VALUE)));

    // Blocks never see privilege, only wr_en
    assign acc.wr_en   = wr_vld && idx_exists(wr_idx) && (wr_idx[9:8] <= pri_level) &&
                         (wr_idx[11:10] != csr_pkg::RO_FIELD_VALUE);
    assign acc.addr    = csr_pkg::csr_addr_e'(wr_idx);
    assign acc.wr_data = wr_data;
    assign acc.rd_addr = csr_pkg::csr_addr_e'(rd_idx);

    always_comb begin
        case (acc.rd_addr)
            csr_pkg::MISA:    rd_mux = csr_pkg::MISA_VALUE;
            csr_pkg::MHARTID: rd_mux = csr_pkg::xlen_t'(HART_ID);
            csr_pkg::MIP:     rd_mux = intr_rd_data;
            csr_pkg::MCOUNTINHIBIT, csr_pkg::MCYCLE, csr_pkg::MINSTRET,
            csr_pkg::MCYCLEH, csr_pkg::MINSTRETH, csr_pkg::CYCLE,
            csr_pkg::INSTRET, csr_pkg::CYCLEH, csr_pkg::INSTRETH:
                              rd_mux = cnt_rd_data;
            default:          rd_mux = trap_rd_data;
        endcase
    end

    assign rd_data = csr_excp ? '0 : rd_mux;

endmodule

// File: verilog/csr_bus_if.sv
//--------------------------------------------------------------------------
// Interfaces inside the CSR unit. csr_access_if carries the decoded access
// from the decoder to the register blocks; trap_if carries trap entry and
// return events from the core into the trap registers.
//--------------------------------------------------------------------------

`timescale 1ns/1ns

interface csr_access_if;
    logic                      wr_en;    // Qualified write
    csr_pkg::csr_addr_e        addr;     // Write address
    csr_pkg::xlen_t            wr_data;
    csr_pkg::csr_addr_e        rd_addr;

    modport decoder (output wr_en, addr, wr_data, rd_addr);
    modport regs    (input  wr_en, addr, wr_data, rd_addr);
endinterface

interface trap_if;
    logic                      trig;     // Trap entry pulse
    logic                      exit;     // Trap return pulse
    logic                      is_intr;
    logic [3:0]                code;
    csr_pkg::xlen_t            epc;
    csr_pkg::xlen_t            info;

    modport source (output trig, exit, is_intr, code, epc, info);
    modport sink   (input  trig, exit, is_intr, code, epc, info);
endinterface

// File: verilog/csr_counters.sv
//--------------------------------------------------------------------------
// Cycle and retired-instruction counters with mcountinhibit. Writes to the
// low or high halves win over the increment; the user shadow addresses
// read the same counters.
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_counters (
    input  logic                  clk,
    input  logic                  rst_n,
    csr_access_if.regs            acc,
    input  logic                  instret_inc,
    output csr_pkg::xlen_t        rd_data
);

    localparam int W = csr_pkg::XLEN;

    csr_pkg::xlen_t mcountinhibit;
    csr_pkg::cnt_t  mcycle, minstret;

    function automatic csr_pkg::cnt_t cnt_next(csr_pkg::cnt_t cnt, logic wr_lo,
                                               logic wr_hi, logic inc,
                                               csr_pkg::xlen_t data);
        csr_pkg::cnt_t nxt;
        nxt = cnt;
        if (wr_lo)      nxt[W-1:0]   = data;
        else if (wr_hi) nxt[63:W]    = data;
        else if (inc)   nxt          = cnt + 64'd1;
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcountinhibit <= csr_pkg::MCOUNTINHIBIT_RESET;
            mcycle        <= '0;
            minstret      <= '0;
        end else begin
            if (acc.wr_en && acc.addr == csr_pkg::MCOUNTINHIBIT) begin
                mcountinhibit <= {acc.wr_data[W-1:2], 1'b0, acc.wr_data[0]};  // No TM bit
            end
            mcycle   <= cnt_next(mcycle, acc.wr_en && acc.addr == csr_pkg::MCYCLE,
                                 acc.wr_en && acc.addr == csr_pkg::MCYCLEH,
                                 !mcountinhibit[0], acc.wr_data);
            minstret <= cnt_next(minstret, acc.wr_en && acc.addr == csr_pkg::MINSTRET,
                                 acc.wr_en && acc.addr == csr_pkg::MINSTRETH,
                                 instret_inc && !mcountinhibit[2], acc.wr_data);
        end
    end

    always_comb begin
        case (acc.rd_addr)
            csr_pkg::MCOUNTINHIBIT:              rd_data = mcountinhibit;
            csr_pkg::MCYCLE,    csr_pkg::CYCLE:    rd_data = mcycle[W-1:0];
            csr_pkg::MCYCLEH,   csr_pkg::CYCLEH:   rd_data = mcycle[63:W];
            csr_pkg::MINSTRET,  csr_pkg::INSTRET:  rd_data = minstret[W-1:0];
            csr_pkg::MINSTRETH, csr_pkg::INSTRETH: rd_data = minstret[63:W];
            default:                             rd_data = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n) mcountinhibit[1] == 1'b0);

endmodule

// File: verilog/csr_intr_pending.sv
//--------------------------------------------------------------------------
// Interrupt pending capture. Each line is sampled, then compared with its
// previous sample; a rising edge sets its mip bit and a falling edge clears
// it one cycle later, only while the hart runs at machine level.
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_intr_pending (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  intr_ext,
    input  logic                  intr_tmr,
    input  logic                  intr_sft,
    input  csr_pkg::priv_e        pri_level,
    csr_access_if.regs            acc,
    output csr_pkg::xlen_t        rd_data
);

    logic [2:0] line_q;    // {ext, tmr, sft}
    logic [2:0] line_qq;
    logic [2:0] rise, fall;
    logic [2:0] pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_q  <= '0;
            line_qq <= '0;
        end else begin
            line_q  <= {intr_ext, intr_tmr, intr_sft};
            line_qq <= line_q;
        end
    end

    assign rise = line_q & ~line_qq;
    assign fall = ~line_q & line_qq;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
        end else if (pri_level == csr_pkg::PRIV_M) begin
            pend <= (pend | rise) & ~fall;   // Each bit on its own line
        end
    end

    // Read only, software writes have no effect
    always_comb begin
        rd_data = '0;
        if (acc.rd_addr == csr_pkg::MIP) begin
            rd_data[csr_pkg::MEI_BIT] = pend[2];
            rd_data[csr_pkg::MTI_BIT] = pend[1];
            rd_data[csr_pkg::MSI_BIT] = pend[0];
        end
    end

endmodule

// File: verilog/csr_pkg.sv
//--------------------------------------------------------------------------
// Shared definitions for the machine-level CSR unit: register width, the
// CSR address map, privilege levels, field bit positions and reset words.
// RTL files refer to these by scoped names.
//--------------------------------------------------------------------------

package csr_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [11:0]     csr_idx_t;
    typedef logic [63:0]     cnt_t;

    typedef enum csr_idx_t {
        MSTATUS       = 12'h300,
        MISA          = 12'h301,
        MIE           = 12'h304,
        MTVEC         = 12'h305,
        MCOUNTINHIBIT = 12'h320,
        MSCRATCH      = 12'h340,
        MEPC          = 12'h341,
        MCAUSE        = 12'h342,
        MTVAL         = 12'h343,
        MIP           = 12'h344,
        MCYCLE        = 12'hB00,
        MINSTRET      = 12'hB02,
        MCYCLEH       = 12'hB80,
        MINSTRETH     = 12'hB82,
        CYCLE         = 12'hC00,
        INSTRET       = 12'hC02,
        CYCLEH        = 12'hC80,
        INSTRETH      = 12'hC82,
        MHARTID       = 12'hF14
    } csr_addr_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_H = 2'd2,
        PRIV_M = 2'd3
    } priv_e;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MEI_BIT          = 11;   // Shared by mie and mip
    localparam int MTI_BIT          = 7;
    localparam int MSI_BIT          = 3;

    localparam logic [1:0] RO_FIELD_VALUE = 2'b11;  // Index bits 11:10

    localparam xlen_t MISA_VALUE          = 32'h4000_1100;  // MXL=1, I, M
    localparam xlen_t MSTATUS_RESET       = 32'h0000_1880;  // MPP=3, MPIE=1
    localparam xlen_t MCOUNTINHIBIT_RESET = 32'hFFFF_FFFD;

endpackage

// File: verilog/csr_trap_regs.sv
//--------------------------------------------------------------------------
// Machine trap setup and handling registers. Trap entry and return update
// mstatus MIE/MPIE; entry at machine level also captures mepc, mcause and
// mtval. Software writes arrive already qualified over the access bus.
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_trap_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    csr_access_if.regs            acc,
    trap_if.sink                  trap,
    input  csr_pkg::priv_e        pri_level,
    output csr_pkg::xlen_t        rd_data,
    output csr_pkg::xlen_t        out_mepc,
    output csr_pkg::xlen_t        out_mtvec,
    output logic                  out_mstatus_mie,
    output logic                  out_mie_meie,
    output logic                  out_mie_mtie,
    output logic                  out_mie_msie
);

    localparam int MIE_B  = csr_pkg::MSTATUS_MIE_BIT;
    localparam int MPIE_B = csr_pkg::MSTATUS_MPIE_BIT;

    csr_pkg::xlen_t mstatus, mie, mtvec, mscratch, mepc, mcause, mtval;
    logic           trap_capture;

    assign trap_capture = trap.trig && (pri_level == csr_pkg::PRIV_M);

    // --------------------------------------------------------------------------
    // Control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= csr_pkg::MSTATUS_RESET;
        end else if (trap.trig) begin
            mstatus[MPIE_B] <= mstatus[MIE_B];
            mstatus[MIE_B]  <= 1'b0;
        end else if (trap.exit) begin
            mstatus[MIE_B]  <= mstatus[MPIE_B];
            mstatus[MPIE_B] <= 1'b1;
        end else if (acc.wr_en && acc.addr == csr_pkg::MSTATUS) begin
            mstatus[MIE_B]  <= acc.wr_data[MIE_B];   // Other fields fixed
            mstatus[MPIE_B] <= acc.wr_data[MPIE_B];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie   <= '0;
            mtvec <= '0;
        end else if (acc.wr_en) begin
            if (acc.addr == csr_pkg::MIE) begin
                mie[csr_pkg::MEI_BIT] <= acc.wr_data[csr_pkg::MEI_BIT];
                mie[csr_pkg::MTI_BIT] <= acc.wr_data[csr_pkg::MTI_BIT];
                mie[csr_pkg::MSI_BIT] <= acc.wr_data[csr_pkg::MSI_BIT];
            end
            if (acc.addr == csr_pkg::MTVEC) begin
                mtvec <= {acc.wr_data[csr_pkg::XLEN-1:2], 1'b0, acc.wr_data[0]};
            end
        end
    end

    // --------------------------------------------------------------------------
    // Trap data
    always_ff @(posedge clk) begin
        if (acc.wr_en && acc.addr == csr_pkg::MSCRATCH) mscratch <= acc.wr_data;
        if (trap_capture) begin
            mepc   <= trap.epc;
            mcause <= {trap.is_intr, {(csr_pkg::XLEN-5){1'b0}}, trap.code};
            mtval  <= trap.info;
        end else if (acc.wr_en) begin
            if (acc.addr == csr_pkg::MEPC)   mepc   <= acc.wr_data;
            if (acc.addr == csr_pkg::MCAUSE) mcause <= acc.wr_data;
            if (acc.addr == csr_pkg::MTVAL)  mtval  <= acc.wr_data;
        end
    end

    always_comb begin
        case (acc.rd_addr)
            csr_pkg::MSTATUS:  rd_data = mstatus;
            csr_pkg::MIE:      rd_data = mie;
            csr_pkg::MTVEC:    rd_data = mtvec;
            csr_pkg::MSCRATCH: rd_data = mscratch;
            csr_pkg::MEPC:     rd_data = mepc;
            csr_pkg::MCAUSE:   rd_data = mcause;
            csr_pkg::MTVAL:    rd_data = mtval;
            default:           rd_data = '0;
        endcase
    end

    assign out_mepc        = mepc;
    assign out_mtvec       = mtvec;
    assign out_mstatus_mie = mstatus[MIE_B];
    assign out_mie_meie    = mie[csr_pkg::MEI_BIT];
    assign out_mie_mtie    = mie[csr_pkg::MTI_BIT];
    assign out_mie_msie    = mie[csr_pkg::MSI_BIT];

    // Entry and return come from the core as lone pulses
    assert property (@(posedge clk) disable iff (!rst_n) !(trap.trig && trap.exit));
    assert property (@(posedge clk) disable iff (!rst_n) trap.trig |=> !trap.trig);

endmodule

// File: verilog/csr_unit_top.sv
//--------------------------------------------------------------------------
// Machine-level CSR unit top. Plain ports toward the core; inside, the
// decoder feeds the trap, interrupt and counter blocks over csr_access_if
// and trap events reach the trap registers over trap_if.
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_unit_top #(
    parameter int HART_ID = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_vld,
    input  logic                  wb_act,
    input  csr_pkg::csr_idx_t     rd_idx,
    output csr_pkg::xlen_t        rd_data,
    input  logic                  wr_vld,
    input  csr_pkg::csr_idx_t     wr_idx,
    input  csr_pkg::xlen_t        wr_data,
    input  csr_pkg::priv_e        pri_level,
    input  logic                  trap_trig,
    input  logic                  trap_exit,
    input  logic                  trap_is_intr,   // 1 interrupt, 0 exception
    input  logic [3:0]            trap_code,
    input  csr_pkg::xlen_t        trap_epc,
    input  csr_pkg::xlen_t        trap_info,
    input  logic                  intr_ext,
    input  logic                  intr_tmr,
    input  logic                  intr_sft,
    input  logic                  instret_inc,
    output csr_pkg::xlen_t        out_mepc,
    output csr_pkg::xlen_t        out_mtvec,
    output logic                  out_mstatus_mie,
    output logic                  out_mie_meie,
    output logic                  out_mie_mtie,
    output logic                  out_mie_msie,
    output logic                  csr_excp
);

    csr_pkg::xlen_t trap_rd_data, intr_rd_data, cnt_rd_data;

    csr_access_if acc ();
    trap_if       trap ();

    // Source side of trap_if
    assign trap.trig    = trap_trig;
    assign trap.exit    = trap_exit;
    assign trap.is_intr = trap_is_intr;
    assign trap.code    = trap_code;
    assign trap.epc     = trap_epc;
    assign trap.info    = trap_info;

    csr_access_decode #(.HART_ID(HART_ID)) u_decode (
        .rd_vld, .wb_act, .rd_idx, .wr_vld, .wr_idx, .wr_data, .pri_level,
        .trap_rd_data, .intr_rd_data, .cnt_rd_data,
        .rd_data, .csr_excp, .acc(acc)
    );

    csr_trap_regs u_trap_regs (
        .clk, .rst_n, .acc(acc), .trap(trap), .pri_level, .rd_data(trap_rd_data),
        .out_mepc, .out_mtvec, .out_mstatus_mie,
        .out_mie_meie, .out_mie_mtie, .out_mie_msie
    );

    csr_intr_pending u_intr_pending (
        .clk, .rst_n, .intr_ext, .intr_tmr, .intr_sft, .pri_level,
        .acc(acc), .rd_data(intr_rd_data)
    );

    csr_counters u_counters (
        .clk, .rst_n, .acc(acc), .instret_inc, .rd_data(cnt_rd_data)
    );

endmodule
